//--- core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and register file
`define CORE_DATA_W   32
`define CORE_REG_NUM  32
`define CORE_ISSUE_W  2

// Instruction word layout, op in the top bits, immediate in the low bits
`define CORE_INSTR_W  32
`define CORE_OP_W     4
`define CORE_OP_LSB   28
`define CORE_RD_LSB   23
`define CORE_RS1_LSB  18
`define CORE_RS2_LSB  13
`define CORE_IMM_W    13

// Cycles from slot 0 issue to slot 1 issue in a split pair
`define CORE_DEP_WAIT 3

`endif

//--- core_pkg.sv
`include "core_consts.svh"

package core_pkg;

    // Architectural data word
    typedef logic [`CORE_DATA_W-1:0] word_t;

    // Register index
    typedef logic [$clog2(`CORE_REG_NUM)-1:0] reg_idx_t;

    // ALU operation codes as found in the op field
    typedef enum logic [`CORE_OP_W-1:0] {
        ALU_NOP  = 0,
        ALU_ADD  = 1,
        ALU_SUB  = 2,
        ALU_AND  = 3,
        ALU_OR   = 4,
        ALU_XOR  = 5,
        ALU_SLT  = 6,
        ALU_ADDI = 7
    } alu_op_e;

endpackage

//--- reg_file.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // Write port 0, slot 0
    input  logic     we0_i,
    input  reg_idx_t waddr0_i,
    input  word_t    wdata0_i,
    // Write port 1, slot 1
    input  logic     we1_i,
    input  reg_idx_t waddr1_i,
    input  word_t    wdata1_i,
    // Two read ports per slot
    input  reg_idx_t raddr_i [2*`CORE_ISSUE_W],
    output word_t    rdata_o [2*`CORE_ISSUE_W]
);

    localparam int ReadPorts = 2 * `CORE_ISSUE_W;

    word_t regs [`CORE_REG_NUM];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < `CORE_REG_NUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (we0_i && (waddr0_i != '0)) begin
                regs[waddr0_i] <= wdata0_i;
            end
            // Port 1 is later in program order, so its write lands last
            if (we1_i && (waddr1_i != '0)) begin
                regs[waddr1_i] <= wdata1_i;
            end
        end
    end

    // Register zero always reads as zero
    for (genvar p = 0; p < ReadPorts; p++) begin : g_read
        assign rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
    end

endmodule

//--- issue_unit.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module issue_unit import core_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n_i,
    // Four-phase instruction pair input
    input  logic                     instr_req_i,
    input  logic [`CORE_INSTR_W-1:0] instr0_i,
    input  logic [`CORE_INSTR_W-1:0] instr1_i,
    output logic                     instr_ack_o,
    // Register file read side
    output reg_idx_t                 raddr_o [2*`CORE_ISSUE_W],
    input  word_t                    rdata_i [2*`CORE_ISSUE_W],
    // To the execution lanes
    output logic                     lane_valid_o [`CORE_ISSUE_W],
    output alu_op_e                  lane_op_o [`CORE_ISSUE_W],
    output word_t                    lane_a_o [`CORE_ISSUE_W],
    output word_t                    lane_b_o [`CORE_ISSUE_W],
    output reg_idx_t                 lane_rd_o [`CORE_ISSUE_W]
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_DEP,
        ST_ACKED
    } state_e;

    localparam int CntW = $clog2(`CORE_DEP_WAIT + 1);
    localparam int IdxW = $bits(reg_idx_t);

    state_e                   state;
    logic [CntW-1:0]          wait_cnt;
    logic [`CORE_INSTR_W-1:0] instr [`CORE_ISSUE_W];
    alu_op_e                  dec_op [`CORE_ISSUE_W];
    reg_idx_t                 dec_rd [`CORE_ISSUE_W];
    reg_idx_t                 dec_rs1 [`CORE_ISSUE_W];
    reg_idx_t                 dec_rs2 [`CORE_ISSUE_W];
    word_t                    dec_b [`CORE_ISSUE_W];
    logic                     dec_wr [`CORE_ISSUE_W];
    logic                     issue_mask [`CORE_ISSUE_W];
    logic                     pair_dep;

    assign instr[0] = instr0_i;
    assign instr[1] = instr1_i;

    for (genvar i = 0; i < `CORE_ISSUE_W; i++) begin : g_dec
        logic [`CORE_IMM_W-1:0] imm;

        assign dec_op[i]  = alu_op_e'(instr[i][`CORE_OP_LSB +: `CORE_OP_W]);
        assign dec_rd[i]  = instr[i][`CORE_RD_LSB +: IdxW];
        assign dec_rs1[i] = instr[i][`CORE_RS1_LSB +: IdxW];
        assign dec_rs2[i] = instr[i][`CORE_RS2_LSB +: IdxW];
        assign imm        = instr[i][`CORE_IMM_W-1:0];

        assign raddr_o[2*i]   = dec_rs1[i];
        assign raddr_o[2*i+1] = dec_rs2[i];

        // Operand b is the sign-extended immediate for ADDI
        assign dec_b[i] = (dec_op[i] == ALU_ADDI) ?
                          {{(`CORE_DATA_W-`CORE_IMM_W){imm[`CORE_IMM_W-1]}}, imm} :
                          rdata_i[2*i+1];

        // NOPs, unknown codes and writes to register zero commit nothing
        assign dec_wr[i] = (dec_op[i] inside {[ALU_ADD:ALU_ADDI]}) && (dec_rd[i] != '0);
    end

    // Slot 1 reads what slot 0 writes
    assign pair_dep = dec_wr[0] && dec_wr[1] &&
                      ((dec_rs1[1] == dec_rd[0]) ||
                       ((dec_op[1] != ALU_ADDI) && (dec_rs2[1] == dec_rd[0])));

    always_comb begin
        for (int i = 0; i < `CORE_ISSUE_W; i++) begin
            issue_mask[i] = 1'b0;
        end
        case (state)
            ST_IDLE: begin
                if (instr_req_i) begin
                    issue_mask[0] = 1'b1;
                    issue_mask[1] = !pair_dep;
                end
            end
            ST_WAIT_DEP: begin
                issue_mask[1] = (wait_cnt == '0);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= ST_IDLE;
            wait_cnt    <= '0;
            instr_ack_o <= 1'b0;
            for (int i = 0; i < `CORE_ISSUE_W; i++) begin
                lane_valid_o[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `CORE_ISSUE_W; i++) begin
                lane_valid_o[i] <= issue_mask[i] && dec_wr[i];
            end
            case (state)
                ST_IDLE: begin
                    if (instr_req_i) begin
                        if (pair_dep) begin
                            // Slot 1 waits until slot 0 sits in the register file
                            state    <= ST_WAIT_DEP;
                            wait_cnt <= CntW'(`CORE_DEP_WAIT - 1);
                        end else begin
                            state       <= ST_ACKED;
                            instr_ack_o <= 1'b1;
                        end
                    end
                end
                ST_WAIT_DEP: begin
                    if (wait_cnt == '0) begin
                        state       <= ST_ACKED;
                        instr_ack_o <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                ST_ACKED: begin
                    if (!instr_req_i) begin
                        state       <= ST_IDLE;
                        instr_ack_o <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Lane payload, loaded only for a slot that issues this cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < `CORE_ISSUE_W; i++) begin
            if (issue_mask[i]) begin
                lane_op_o[i] <= dec_op[i];
                lane_a_o[i]  <= rdata_i[2*i];
                lane_b_o[i]  <= dec_b[i];
                lane_rd_o[i] <= dec_rd[i];
            end
        end
    end

endmodule

//--- alu_lane.sv
`timescale 1ns/1ps

module alu_lane import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // From issue
    input  logic     valid_i,
    input  alu_op_e  op_i,
    input  word_t    a_i,
    input  word_t    b_i,
    input  reg_idx_t rd_i,
    // To commit
    output logic     valid_o,
    output reg_idx_t rd_o,
    output word_t    result_o
);

    word_t alu_res;

    always_comb begin
        case (op_i)
            ALU_ADD,
            ALU_ADDI: alu_res = a_i + b_i;
            ALU_SUB:  alu_res = a_i - b_i;
            ALU_AND:  alu_res = a_i & b_i;
            ALU_OR:   alu_res = a_i | b_i;
            ALU_XOR:  alu_res = a_i ^ b_i;
            // Signed compare, result is 1 or 0
            ALU_SLT:  alu_res = word_t'($signed(a_i) < $signed(b_i));
            default:  alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // One item in flight per lane
    always_ff @(posedge clk) begin
        if (valid_i) begin
            rd_o     <= rd_i;
            result_o <= alu_res;
        end
    end

endmodule

//--- commit_unit.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module commit_unit import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // From the lanes
    input  logic     lane_valid_i [`CORE_ISSUE_W],
    input  reg_idx_t lane_rd_i [`CORE_ISSUE_W],
    input  word_t    lane_result_i [`CORE_ISSUE_W],
    // Register file write ports
    output logic     we0_o,
    output reg_idx_t waddr0_o,
    output word_t    wdata0_o,
    output logic     we1_o,
    output reg_idx_t waddr1_o,
    output word_t    wdata1_o,
    // Writeback report
    output logic     wb0_valid_o,
    output reg_idx_t wb0_rnum_o,
    output word_t    wb0_data_o,
    output logic     wb1_valid_o,
    output reg_idx_t wb1_rnum_o,
    output word_t    wb1_data_o
);

    // Lane order is program order, port 1 wins in the register file
    assign we0_o    = lane_valid_i[0];
    assign waddr0_o = lane_rd_i[0];
    assign wdata0_o = lane_result_i[0];
    assign we1_o    = lane_valid_i[1];
    assign waddr1_o = lane_rd_i[1];
    assign wdata1_o = lane_result_i[1];

    // Report lines up with the edge that updates the register file
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb0_valid_o <= 1'b0;
            wb1_valid_o <= 1'b0;
        end else begin
            wb0_valid_o <= we0_o;
            wb1_valid_o <= we1_o;
        end
    end

    always_ff @(posedge clk) begin
        if (we0_o) begin
            wb0_rnum_o <= waddr0_o;
            wb0_data_o <= wdata0_o;
        end
        if (we1_o) begin
            wb1_rnum_o <= waddr1_o;
            wb1_data_o <= wdata1_o;
        end
    end

endmodule

//--- core_top.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_top import core_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n_i,
    // Instruction pair handshake
    input  logic                     instr_req_i,
    input  logic [`CORE_INSTR_W-1:0] instr0_i,
    input  logic [`CORE_INSTR_W-1:0] instr1_i,
    output logic                     instr_ack_o,
    // Writeback report per slot
    output logic                     wb0_valid_o,
    output reg_idx_t                 wb0_rnum_o,
    output word_t                    wb0_data_o,
    output logic                     wb1_valid_o,
    output reg_idx_t                 wb1_rnum_o,
    output word_t                    wb1_data_o
);

    // Issue to register file
    reg_idx_t rf_raddr [2*`CORE_ISSUE_W];
    word_t    rf_rdata [2*`CORE_ISSUE_W];

    // Issue to lanes
    logic     iss_valid [`CORE_ISSUE_W];
    alu_op_e  iss_op [`CORE_ISSUE_W];
    word_t    iss_a [`CORE_ISSUE_W];
    word_t    iss_b [`CORE_ISSUE_W];
    reg_idx_t iss_rd [`CORE_ISSUE_W];

    // Lanes to commit
    logic     ex_valid [`CORE_ISSUE_W];
    reg_idx_t ex_rd [`CORE_ISSUE_W];
    word_t    ex_result [`CORE_ISSUE_W];

    // Commit to register file
    logic     rf_we0;
    reg_idx_t rf_waddr0;
    word_t    rf_wdata0;
    logic     rf_we1;
    reg_idx_t rf_waddr1;
    word_t    rf_wdata1;

    issue_unit u_issue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .instr_req_i  (instr_req_i),
        .instr0_i     (instr0_i),
        .instr1_i     (instr1_i),
        .instr_ack_o  (instr_ack_o),
        .raddr_o      (rf_raddr),
        .rdata_i      (rf_rdata),
        .lane_valid_o (iss_valid),
        .lane_op_o    (iss_op),
        .lane_a_o     (iss_a),
        .lane_b_o     (iss_b),
        .lane_rd_o    (iss_rd)
    );

    for (genvar i = 0; i < `CORE_ISSUE_W; i++) begin : g_lane
        alu_lane u_alu_lane (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .valid_i  (iss_valid[i]),
            .op_i     (iss_op[i]),
            .a_i      (iss_a[i]),
            .b_i      (iss_b[i]),
            .rd_i     (iss_rd[i]),
            .valid_o  (ex_valid[i]),
            .rd_o     (ex_rd[i]),
            .result_o (ex_result[i])
        );
    end

    commit_unit u_commit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .lane_valid_i  (ex_valid),
        .lane_rd_i     (ex_rd),
        .lane_result_i (ex_result),
        .we0_o         (rf_we0),
        .waddr0_o      (rf_waddr0),
        .wdata0_o      (rf_wdata0),
        .we1_o         (rf_we1),
        .waddr1_o      (rf_waddr1),
        .wdata1_o      (rf_wdata1),
        .wb0_valid_o   (wb0_valid_o),
        .wb0_rnum_o    (wb0_rnum_o),
        .wb0_data_o    (wb0_data_o),
        .wb1_valid_o   (wb1_valid_o),
        .wb1_rnum_o    (wb1_rnum_o),
        .wb1_data_o    (wb1_data_o)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we0_i    (rf_we0),
        .waddr0_i (rf_waddr0),
        .wdata0_i (rf_wdata0),
        .we1_i    (rf_we1),
        .waddr1_i (rf_waddr1),
        .wdata1_i (rf_wdata1),
        .raddr_i  (rf_raddr),
        .rdata_o  (rf_rdata)
    );

endmodule

//--- core_tb.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb import core_pkg::*; ();

    localparam int MaxLines = 64;
    localparam int Fields   = 6;

    logic                     clk = 1'b0;
    logic                     rst_n_i;
    logic                     instr_req_i;
    logic [`CORE_INSTR_W-1:0] instr0_i;
    logic [`CORE_INSTR_W-1:0] instr1_i;
    logic                     instr_ack_o;
    logic                     wb0_valid_o;
    reg_idx_t                 wb0_rnum_o;
    word_t                    wb0_data_o;
    logic                     wb1_valid_o;
    reg_idx_t                 wb1_rnum_o;
    word_t                    wb1_data_o;

    // Per line: instr0, instr1, valid0, data0, valid1, data1
    logic [31:0] trace_mem [Fields*MaxLines];
    int          n_lines;
    int          cyc = 0;
    int          timeout_cyc = 0;
    int          errors = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;
    logic [31:0] lfsr = 32'h2b015b66;
    logic        prev_req = 1'b0;
    logic        prev_ack = 1'b0;

    // Writebacks seen by the monitor, one entry per valid pulse
    int       wb0_cyc [$];
    reg_idx_t wb0_num [$];
    word_t    wb0_dat [$];
    int       wb1_cyc [$];
    reg_idx_t wb1_num [$];
    word_t    wb1_dat [$];

    core_top uut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .instr_req_i (instr_req_i),
        .instr0_i    (instr0_i),
        .instr1_i    (instr1_i),
        .instr_ack_o (instr_ack_o),
        .wb0_valid_o (wb0_valid_o),
        .wb0_rnum_o  (wb0_rnum_o),
        .wb0_data_o  (wb0_data_o),
        .wb1_valid_o (wb1_valid_o),
        .wb1_rnum_o  (wb1_rnum_o),
        .wb1_data_o  (wb1_data_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (timeout_cyc > 0 && cyc >= timeout_cyc) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cyc);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Monitor, sampled in the middle of the low phase
    always @(negedge clk) begin
        if (wb0_valid_o) begin
            wb0_cyc.push_back(cyc);
            wb0_num.push_back(wb0_rnum_o);
            wb0_dat.push_back(wb0_data_o);
        end
        if (wb1_valid_o) begin
            wb1_cyc.push_back(cyc);
            wb1_num.push_back(wb1_rnum_o);
            wb1_dat.push_back(wb1_data_o);
        end
        if (instr_ack_o && !prev_ack) begin
            assert (prev_req && instr_req_i) else begin
                $display("Handshake fault at %0t: ack rose while the request was low", $time);
                errors++;
            end
        end
        if (!instr_ack_o && prev_ack) begin
            assert (!prev_req && !instr_req_i) else begin
                $display("Handshake fault at %0t: ack fell while the request was high", $time);
                errors++;
            end
        end
        prev_req = instr_req_i;
        prev_ack = instr_ack_o;
    end

    // Galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic int idle_gap();
        int g;
        g = 0;
        for (int b = 0; b < 3; b++) begin
            g = (g << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return g;
    endfunction

    function automatic reg_idx_t rd_field(input logic [31:0] w);
        return w[`CORE_RD_LSB +: 5];
    endfunction

    // ADDI takes the immediate instead of rs2
    function automatic logic reads_reg(input logic [31:0] w, input reg_idx_t r);
        logic uses_rs2;
        uses_rs2 = (w[`CORE_OP_LSB +: `CORE_OP_W] != ALU_ADDI);
        return (w[`CORE_RS1_LSB +: 5] == r) || (uses_rs2 && (w[`CORE_RS2_LSB +: 5] == r));
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("Fail t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_cycle(input string name, input int exp, input int got);
        assert (got == exp) else begin
            $display("Fail t=%0t %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic expect_quiet();
        check_val("instr_ack_o", 32'd0, instr_ack_o);
        check_val("wb0_valid_o", 32'd0, wb0_valid_o);
        check_val("wb1_valid_o", 32'd0, wb1_valid_o);
    endtask

    task automatic check_slot(input int slot, input logic exp_v, input int exp_cyc,
                              input reg_idx_t exp_rd, input word_t exp_data);
        int       n;
        int       got_cyc;
        reg_idx_t got_rd;
        word_t    got_data;
        n = 0;
        got_cyc = 0;
        got_rd = '0;
        got_data = '0;
        if (slot == 0) begin
            n = wb0_cyc.size();
            if (n > 0) begin
                got_cyc = wb0_cyc[0];
                got_rd = wb0_num[0];
                got_data = wb0_dat[0];
            end
        end else begin
            n = wb1_cyc.size();
            if (n > 0) begin
                got_cyc = wb1_cyc[0];
                got_rd = wb1_num[0];
                got_data = wb1_dat[0];
            end
        end
        if (exp_v) begin
            assert (n == 1) else begin
                $display("Slot %0d should write back once but wrote back %0d times", slot, n);
                errors++;
            end
            if (n > 0) begin
                check_cycle($sformatf("wb%0d_valid_o cycle", slot), exp_cyc, got_cyc);
                check_val($sformatf("wb%0d_rnum_o", slot), exp_rd, got_rd);
                check_val($sformatf("wb%0d_data_o", slot), exp_data, got_data);
            end
        end else begin
            assert (n == 0) else begin
                $display("Slot %0d wrote back although its write is suppressed", slot);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_pass++;
            $display("%s: pass", name);
        end else begin
            tests_fail++;
            $display("%s: fail", name);
        end
    endtask

    task automatic run_pair(input int t);
        logic [31:0] w0;
        logic [31:0] w1;
        logic        v0;
        logic        v1;
        logic        dep;
        int          gap;
        int          first_cyc;
        int          ack_cyc;
        int          err_start;
        w0 = trace_mem[Fields*t];
        w1 = trace_mem[Fields*t+1];
        v0 = trace_mem[Fields*t+2][0];
        v1 = trace_mem[Fields*t+4][0];
        dep = v0 && v1 && reads_reg(w1, rd_field(w0));
        err_start = errors;
        gap = idle_gap();
        repeat (gap) @(posedge clk);
        @(posedge clk);
        instr0_i    <= w0;
        instr1_i    <= w1;
        instr_req_i <= 1'b1;
        @(negedge clk);
        // The DUT samples the request on the next edge
        first_cyc = cyc + 1;
        while (!instr_ack_o) @(negedge clk);
        ack_cyc = cyc;
        check_cycle("instr_ack_o rise cycle", first_cyc + (dep ? `CORE_DEP_WAIT : 0), ack_cyc);
        @(posedge clk);
        instr_req_i <= 1'b0;
        @(negedge clk);
        while (instr_ack_o) @(negedge clk);
        // Let the monitor take the last writeback pulse
        @(negedge clk);
        check_slot(0, v0, first_cyc + 2, rd_field(w0), trace_mem[Fields*t+3]);
        check_slot(1, v1, ack_cyc + 2, rd_field(w1), trace_mem[Fields*t+5]);
        wb0_cyc.delete();
        wb0_num.delete();
        wb0_dat.delete();
        wb1_cyc.delete();
        wb1_num.delete();
        wb1_dat.delete();
        report_test($sformatf("test %0d %s", t + 1, dep ? "split pair" : "pair"), err_start);
    endtask

    initial begin
        int err_start;
        rst_n_i     = 1'b0;
        instr_req_i = 1'b0;
        instr0_i    = '0;
        instr1_i    = '0;
        $readmemh("core_trace.txt", trace_mem);
        n_lines = 0;
        while (n_lines < MaxLines && !$isunknown(trace_mem[Fields*n_lines])) n_lines++;
        timeout_cyc = n_lines * 20 + 50;

        err_start = errors;
        repeat (2) begin
            @(negedge clk);
            expect_quiet();
        end
        @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            expect_quiet();
        end
        report_test("test 0 reset", err_start);

        if (n_lines == 0) begin
            $display("No instruction pairs could be read from core_trace.txt");
            errors++;
            tests_fail++;
        end
        for (int t = 0; t < n_lines; t++) begin
            run_pair(t);
        end

        $display("Tests passed %0d, tests failed %0d, check errors %0d",
                 tests_pass, tests_fail, errors);
        if (errors == 0 && tests_fail == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- core_trace.txt
// instr0   instr1   v0 wb0_data v1 wb1_data
// one instruction pair per line, all fields in hex
70800064 71001FFB 1 00000064 1 FFFFFFFB
11844000 22044000 1 0000005F 1 00000069
32846000 43046000 1 00000044 1 0000007F
53844000 64082000 1 FFFFFF9F 1 00000001
64844000 75081ED4 1 00000000 1 FFFFFECF
65A84000 26082000 1 00000001 1 FFFFFF97
76840007 17342000 1 0000006B 1 000000CF
27846000 5809E000 1 00000005 1 FFFFFFFE
70040037 02846000 0 00000000 0 00000000
18800000 4900A000 1 00000000 1 00000044
00000000 79801FFF 0 00000000 1 FFFFFFFF
1A042000 20044000 1 000000C8 0 00000000
7A80000B 7A800016 1 0000000B 1 00000016
1B540000 5BD42000 1 00000016 1 00000072
7C0003E8 1C630000 1 000003E8 1 000007D0
2CE2A000 3D330000 1 000007BA 1 00000790
7D800FFF 7E077000 1 00000FFF 1 FFFFF064
1EEF8000 6F736000 1 00000063 1 00000001
70040003 1F802000 0 00000000 1 00000064
20802000 61040000 1 FFFFFF9C 1 00000001

//--- verilog.f
+incdir+.
core_pkg.sv
reg_file.sv
issue_unit.sv
alu_lane.sv
commit_unit.sv
core_top.sv
core_tb.sv
